/* npu_pkg.sv */
// ######################################################################
// npu tile shared constants
// ######################################################################

`default_nettype none

package npu_pkg;

    // signed byte for weights, inputs and results
    localparam int DATA_W  = 8;

    // dot product and bias
    localparam int ACC_W   = 20;

    // result address, 64 buffer entries
    localparam int ADDR_W  = 6;

    // cells in the row, also the vector length
    localparam int ARRAY_N = 4;

    // requantization shift amount
    localparam int SHIFT_W = 4;

    // clipped-result counter, holds a full burst of 64
    localparam int CNT_W   = ADDR_W + 1;

    // saturation limits of a signed byte
    localparam logic signed [DATA_W-1:0] RES_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic signed [DATA_W-1:0] RES_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // activation burst tracking states
    localparam logic ST_IDLE   = 1'b0;
    localparam logic ST_ACTIVE = 1'b1;

endpackage

`default_nettype wire

/* acc_stream_if.sv */
// ######################################################################
// result stream interface
// ######################################################################

`timescale 1ns/10ps
`default_nettype none

interface acc_stream_if;

    logic                        valid;
    logic                        last;
    logic [npu_pkg::DATA_W-1:0]  result;
    logic [npu_pkg::ADDR_W-1:0]  address;

    // no ready, the sink takes every beat
    modport src (
        output valid,
        output last,
        output result,
        output address
    );

    modport dst (
        input  valid,
        input  last,
        input  result,
        input  address
    );

endinterface

`default_nettype wire

/* mac_pe.sv */
// ######################################################################
// systolic multiply-accumulate cell
// ######################################################################

`timescale 1ns/10ps
`default_nettype none

module mac_pe (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       w_load_i,
    input  wire logic [npu_pkg::DATA_W-1:0] w_i,
    input  wire logic [npu_pkg::DATA_W-1:0] x_i,
    input  wire logic [npu_pkg::ACC_W-1:0]  psum_i,
    output      logic [npu_pkg::ACC_W-1:0]  psum_o
);

    import npu_pkg::*;

    logic        [DATA_W-1:0]   w_q;
    logic signed [2*DATA_W-1:0] prod;

    // stationary weight
    always_ff @(posedge clk) begin
        if (!rst) begin
            w_q <= '0;
        end else if (w_load_i) begin
            w_q <= w_i;
        end
    end

    always_comb begin
        prod = $signed(w_q) * $signed(x_i);
    end

    // product is sign extended into the accumulator width
    always_ff @(posedge clk) begin
        if (!rst) begin
            psum_o <= '0;
        end else begin
            psum_o <= $signed(psum_i) + ACC_W'(prod);
        end
    end

endmodule

`default_nettype wire

/* mac_row.sv */
// ######################################################################
// linear systolic row with input skew
// ######################################################################

`timescale 1ns/10ps
`default_nettype none

module mac_row (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire logic                                         w_load_i,
    input  wire logic [npu_pkg::ARRAY_N*npu_pkg::DATA_W-1:0]  w_vec_i,
    input  wire logic                                         x_valid_i,
    input  wire logic                                         x_last_i,
    input  wire logic [npu_pkg::ARRAY_N*npu_pkg::DATA_W-1:0]  x_vec_i,
    output      logic                                         dot_valid_o,
    output      logic                                         dot_last_o,
    output      logic [npu_pkg::ACC_W-1:0]                    dot_o
);

    import npu_pkg::*;

    logic [ACC_W-1:0]   psum [0:ARRAY_N];
    logic [ARRAY_N-1:0] valid_sr;
    logic [ARRAY_N-1:0] last_sr;

    assign psum[0] = '0;

    // ##################################################################
    // cells, element k reaches cell k after k cycles
    // ##################################################################
    for (genvar k = 0; k < ARRAY_N; k++) begin : g_cell
        logic [DATA_W-1:0] x_skew;

        if (k == 0) begin : g_direct
            assign x_skew = x_vec_i[0 +: DATA_W];
        end else begin : g_delay
            logic [DATA_W-1:0] skew_q [0:k-1];

            always_ff @(posedge clk) begin
                skew_q[0] <= x_vec_i[k*DATA_W +: DATA_W];
                for (int s = 1; s < k; s++) begin
                    skew_q[s] <= skew_q[s-1];
                end
            end

            assign x_skew = skew_q[k-1];
        end

        mac_pe u_pe (
            .clk      (clk),
            .rst      (rst),
            .w_load_i (w_load_i),
            .w_i      (w_vec_i[k*DATA_W +: DATA_W]),
            .x_i      (x_skew),
            .psum_i   (psum[k]),
            .psum_o   (psum[k+1])
        );
    end

    // framing follows the sum through the last cell
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_sr <= '0;
            last_sr  <= '0;
        end else begin
            valid_sr <= {valid_sr[ARRAY_N-2:0], x_valid_i};
            last_sr  <= {last_sr[ARRAY_N-2:0], x_valid_i & x_last_i};
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (!rst) begin
            dot_valid_o <= 1'b0;
            dot_last_o  <= 1'b0;
            dot_o       <= '0;
        end else begin
            dot_valid_o <= valid_sr[ARRAY_N-1];
            dot_last_o  <= last_sr[ARRAY_N-1];
            dot_o       <= psum[ARRAY_N];
        end
    end

endmodule

`default_nettype wire

/* requant_acc.sv */
// ######################################################################
// requantization to a signed byte
// ######################################################################

`timescale 1ns/10ps
`default_nettype none

module requant_acc (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        in_valid_i,
    input  wire logic                        in_last_i,
    input  wire logic [npu_pkg::ACC_W-1:0]   dot_i,
    input  wire logic [npu_pkg::ACC_W-1:0]   bias_i,
    input  wire logic [npu_pkg::SHIFT_W-1:0] shift_i,
    acc_stream_if.src                        acc_s
);

    import npu_pkg::*;

    // one extra bit so the bias add cannot overflow
    logic signed [ACC_W:0]  biased;
    logic signed [ACC_W:0]  shifted;
    logic [DATA_W-1:0]      sat;
    logic [ADDR_W-1:0]      idx_q;

    always_comb begin
        biased  = $signed({dot_i[ACC_W-1], dot_i}) + $signed({bias_i[ACC_W-1], bias_i});
        shifted = biased >>> shift_i;

        if (shifted > RES_MAX) begin
            sat = RES_MAX;
        end else if (shifted < RES_MIN) begin
            sat = RES_MIN;
        end else begin
            sat = shifted[DATA_W-1:0];
        end
    end

    // ##################################################################
    // framing and burst index
    // ##################################################################
    always_ff @(posedge clk) begin
        if (!rst) begin
            acc_s.valid <= 1'b0;
            acc_s.last  <= 1'b0;
            idx_q       <= '0;
        end else begin
            acc_s.valid <= in_valid_i;
            acc_s.last  <= in_valid_i & in_last_i;

            // index restarts after the last beat
            if (in_valid_i) begin
                if (in_last_i) begin
                    idx_q <= '0;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            acc_s.result  <= sat;
            acc_s.address <= idx_q;
        end
    end

endmodule

`default_nettype wire

/* activation_relu.sv */
// ######################################################################
// relu stage with clip count
// ######################################################################

`timescale 1ns/10ps
`default_nettype none

module activation_relu (
    input  wire logic                      clk,
    input  wire logic                      rst,
    acc_stream_if.dst                      acc_s,
    acc_stream_if.src                      act_s,
    output      logic [npu_pkg::CNT_W-1:0] zeros_o
);

    import npu_pkg::*;

    logic             state_q;
    logic             state_d;
    logic             clip;
    logic [CNT_W-1:0] cnt_base;
    logic [CNT_W-1:0] cnt_q;

    always_comb begin
        clip     = acc_s.result[DATA_W-1];
        state_d  = state_q;
        cnt_base = cnt_q;

        case (state_q)
            ST_IDLE: begin
                // first beat opens a burst, count starts fresh
                cnt_base = '0;
                if (acc_s.valid && !acc_s.last) begin
                    state_d = ST_ACTIVE;
                end
            end
            ST_ACTIVE: begin
                if (acc_s.valid && acc_s.last) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q     <= ST_IDLE;
            cnt_q       <= '0;
            zeros_o     <= '0;
            act_s.valid <= 1'b0;
            act_s.last  <= 1'b0;
        end else begin
            state_q     <= state_d;
            act_s.valid <= acc_s.valid;
            act_s.last  <= acc_s.valid & acc_s.last;

            if (acc_s.valid) begin
                cnt_q <= cnt_base + CNT_W'(clip);
            end

            // publish the finished burst count one cycle after its last beat
            if (act_s.valid && act_s.last) begin
                zeros_o <= cnt_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_s.valid) begin
            act_s.result  <= clip ? '0 : acc_s.result;
            act_s.address <= acc_s.address;
        end
    end

endmodule

`default_nettype wire

/* result_buffer.sv */
// ######################################################################
// result memory
// ######################################################################

`timescale 1ns/10ps
`default_nettype none

module result_buffer (
    input  wire logic                       clk,
    input  wire logic                       rst,
    acc_stream_if.dst                       act_s,
    input  wire logic [npu_pkg::ADDR_W-1:0] rd_addr_i,
    output      logic [npu_pkg::DATA_W-1:0] rd_data_o,
    output      logic                       done_o
);

    import npu_pkg::*;

    logic [DATA_W-1:0] mem [0:2**ADDR_W-1];

    // write port
    always_ff @(posedge clk) begin
        if (act_s.valid) begin
            mem[act_s.address] <= act_s.result;
        end
    end

    // registered read port, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    // one-cycle pulse after the last beat is stored
    always_ff @(posedge clk) begin
        if (!rst) begin
            done_o <= 1'b0;
        end else begin
            done_o <= act_s.valid & act_s.last;
        end
    end

endmodule

`default_nettype wire

/* npu_tile.sv */
// ######################################################################
// npu tile top level
// ######################################################################

`timescale 1ns/10ps
`default_nettype none

module npu_tile (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire logic                                         w_load_i,
    input  wire logic [npu_pkg::ARRAY_N*npu_pkg::DATA_W-1:0]  w_vec_i,
    input  wire logic                                         x_valid_i,
    input  wire logic                                         x_last_i,
    input  wire logic [npu_pkg::ARRAY_N*npu_pkg::DATA_W-1:0]  x_vec_i,
    input  wire logic [npu_pkg::ACC_W-1:0]                    bias_i,
    input  wire logic [npu_pkg::SHIFT_W-1:0]                  shift_i,
    input  wire logic [npu_pkg::ADDR_W-1:0]                   rd_addr_i,
    output      logic [npu_pkg::DATA_W-1:0]                   rd_data_o,
    output      logic                                         done_o,
    output      logic [npu_pkg::CNT_W-1:0]                    zeros_o
);

    import npu_pkg::*;

    logic             dot_valid;
    logic             dot_last;
    logic [ACC_W-1:0] dot;

    acc_stream_if acc_s ();
    acc_stream_if act_s ();

    mac_row u_mac_row (
        .clk         (clk),
        .rst         (rst),
        .w_load_i    (w_load_i),
        .w_vec_i     (w_vec_i),
        .x_valid_i   (x_valid_i),
        .x_last_i    (x_last_i),
        .x_vec_i     (x_vec_i),
        .dot_valid_o (dot_valid),
        .dot_last_o  (dot_last),
        .dot_o       (dot)
    );

    requant_acc u_requant_acc (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (dot_valid),
        .in_last_i  (dot_last),
        .dot_i      (dot),
        .bias_i     (bias_i),
        .shift_i    (shift_i),
        .acc_s      (acc_s.src)
    );

    activation_relu u_activation_relu (
        .clk     (clk),
        .rst     (rst),
        .acc_s   (acc_s.dst),
        .act_s   (act_s.src),
        .zeros_o (zeros_o)
    );

    result_buffer u_result_buffer (
        .clk       (clk),
        .rst       (rst),
        .act_s     (act_s.dst),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o),
        .done_o    (done_o)
    );

endmodule

`default_nettype wire

/* npu_checker.sv */
// ######################################################################
// npu tile reference checker
// ######################################################################

`timescale 1ns/10ps
`default_nettype none

module npu_checker (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire logic [3:0]                                   test_id_i,
    input  wire logic                                         rd_check_i,
    input  wire logic                                         w_load_i,
    input  wire logic [npu_pkg::ARRAY_N*npu_pkg::DATA_W-1:0]  w_vec_i,
    input  wire logic                                         x_valid_i,
    input  wire logic                                         x_last_i,
    input  wire logic [npu_pkg::ARRAY_N*npu_pkg::DATA_W-1:0]  x_vec_i,
    input  wire logic [npu_pkg::ACC_W-1:0]                    bias_i,
    input  wire logic [npu_pkg::SHIFT_W-1:0]                  shift_i,
    input  wire logic [npu_pkg::ADDR_W-1:0]                   rd_addr_i,
    input  wire logic [npu_pkg::DATA_W-1:0]                   rd_data_i,
    input  wire logic                                         done_i,
    input  wire logic [npu_pkg::CNT_W-1:0]                    zeros_i,
    output      int                                           mismatch_cnt_o,
    output      int                                           fault_cnt_o
);

    import npu_pkg::*;

    localparam int SAT_HI = 2**(DATA_W-1) - 1;
    localparam int SAT_LO = -(2**(DATA_W-1));

    logic [ARRAY_N*DATA_W-1:0] w_q;
    logic [DATA_W-1:0]         exp_mem [0:2**ADDR_W-1];
    logic [ADDR_W-1:0]         idx;
    logic [ADDR_W-1:0]         rd_addr_q;
    logic                      rd_pend;
    int                        cyc;
    int                        burst_zeros;
    int                        res;
    int                        due_q [$];
    int                        zeros_q [$];

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "random";
            4'd2:    return "saturation";
            4'd3:    return "clip count";
            4'd4:    return "back to back";
            4'd5:    return "weight change";
            default: return "idle";
        endcase
    endfunction

    // dot product, bias, arithmetic shift and saturation, before relu
    function automatic int requant(input logic [ARRAY_N*DATA_W-1:0] w,
                                   input logic [ARRAY_N*DATA_W-1:0] x,
                                   input logic [ACC_W-1:0]          b,
                                   input logic [SHIFT_W-1:0]        sh);
        logic signed [DATA_W-1:0] wk;
        logic signed [DATA_W-1:0] xk;
        int                       acc;
        acc = int'($signed(b));
        for (int k = 0; k < ARRAY_N; k++) begin
            wk  = w[k*DATA_W +: DATA_W];
            xk  = x[k*DATA_W +: DATA_W];
            acc = acc + int'(wk) * int'(xk);
        end
        acc = acc >>> sh;
        if (acc > SAT_HI) begin
            acc = SAT_HI;
        end else if (acc < SAT_LO) begin
            acc = SAT_LO;
        end
        return acc;
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            cyc         = 0;
            idx         = '0;
            burst_zeros = 0;
            rd_pend     = 1'b0;
            due_q.delete();
            zeros_q.delete();
        end else begin
            cyc++;

            // read data belongs to the address sampled one edge earlier
            if (rd_pend && rd_data_i !== exp_mem[rd_addr_q]) begin
                $display("mismatch %s: rd_data_o at address %0d, expected %0d, actual %0d",
                         test_name(test_id_i), rd_addr_q, $signed(exp_mem[rd_addr_q]),
                         $signed(rd_data_i));
                mismatch_cnt_o++;
            end
            rd_pend   = rd_check_i;
            rd_addr_q = rd_addr_i;

            // ##########################################################
            // done pulse and clip count
            // ##########################################################
            if (done_i) begin
                if (due_q.size() == 0) begin
                    $display("done_o pulsed with no burst pending in test %s",
                             test_name(test_id_i));
                    fault_cnt_o++;
                end else begin
                    if (due_q[0] != cyc) begin
                        $display("done_o came at cycle %0d instead of cycle %0d in test %s",
                                 cyc, due_q[0], test_name(test_id_i));
                        fault_cnt_o++;
                    end
                    if (zeros_i !== CNT_W'(zeros_q[0])) begin
                        $display("mismatch %s: zeros_o expected %0d, actual %0d",
                                 test_name(test_id_i), zeros_q[0], zeros_i);
                        mismatch_cnt_o++;
                    end
                    void'(due_q.pop_front());
                    void'(zeros_q.pop_front());
                end
            end else if (due_q.size() > 0 && cyc >= due_q[0]) begin
                $display("done_o never came for the burst due at cycle %0d in test %s",
                         due_q[0], test_name(test_id_i));
                fault_cnt_o++;
                void'(due_q.pop_front());
                void'(zeros_q.pop_front());
            end

            if (x_valid_i) begin
                res = requant(w_q, x_vec_i, bias_i, shift_i);
                if (res < 0) begin
                    burst_zeros++;
                    res = 0;
                end
                exp_mem[idx] = DATA_W'(res);
                if (x_last_i) begin
                    due_q.push_back(cyc + ARRAY_N + 4);
                    zeros_q.push_back(burst_zeros);
                    burst_zeros = 0;
                    idx         = '0;
                end else begin
                    idx++;
                end
            end

            // a beat on the load edge still sees the old weights
            if (w_load_i) begin
                w_q = w_vec_i;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_npu_tile.sv */
// ######################################################################
// npu tile testbench
// ######################################################################

`timescale 1ns/10ps
`default_nettype none

module tb_npu_tile;

    import npu_pkg::*;

    localparam int NUM_BURSTS = 16;
    localparam int BURST_COST = ARRAY_N + 12;
    localparam int MARGIN     = 200;
    localparam int DONE_LIMIT = 2 * ARRAY_N + 16;

    logic                      clk;
    logic                      rst;
    logic                      w_load_i;
    logic [ARRAY_N*DATA_W-1:0] w_vec_i;
    logic                      x_valid_i;
    logic                      x_last_i;
    logic [ARRAY_N*DATA_W-1:0] x_vec_i;
    logic [ACC_W-1:0]          bias_i;
    logic [SHIFT_W-1:0]        shift_i;
    logic [ADDR_W-1:0]         rd_addr_i;
    logic [DATA_W-1:0]         rd_data_o;
    logic                      done_o;
    logic [CNT_W-1:0]          zeros_o;
    logic [3:0]                test_id;
    logic                      rd_check;
    int                        mismatch_cnt;
    int                        fault_cnt;
    int                        timeout_cnt;
    int                        done_seen;
    int                        bursts_sent;
    int                        burst_no;
    int                        cycle_budget;
    int                        len_tab [NUM_BURSTS];
    int unsigned               seed;

    npu_tile npu_tile_i (
        .clk       (clk),
        .rst       (rst),
        .w_load_i  (w_load_i),
        .w_vec_i   (w_vec_i),
        .x_valid_i (x_valid_i),
        .x_last_i  (x_last_i),
        .x_vec_i   (x_vec_i),
        .bias_i    (bias_i),
        .shift_i   (shift_i),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o),
        .done_o    (done_o),
        .zeros_o   (zeros_o)
    );

    npu_checker checker_i (
        .clk            (clk),
        .rst            (rst),
        .test_id_i      (test_id),
        .rd_check_i     (rd_check),
        .w_load_i       (w_load_i),
        .w_vec_i        (w_vec_i),
        .x_valid_i      (x_valid_i),
        .x_last_i       (x_last_i),
        .x_vec_i        (x_vec_i),
        .bias_i         (bias_i),
        .shift_i        (shift_i),
        .rd_addr_i      (rd_addr_i),
        .rd_data_i      (rd_data_o),
        .done_i         (done_o),
        .zeros_i        (zeros_o),
        .mismatch_cnt_o (mismatch_cnt),
        .fault_cnt_o    (fault_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst && done_o) begin
            done_seen <= done_seen + 1;
        end
    end

    // watchdog, armed once the burst lengths are known
    initial begin
        wait (cycle_budget > 0);
        repeat (cycle_budget) @(posedge clk);
        $display("watchdog expired after %0d cycles", cycle_budget);
        $display("test failed");
        $finish;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    function automatic logic [ARRAY_N*DATA_W-1:0] rand_vec(input int lo, input int hi);
        logic [ARRAY_N*DATA_W-1:0] v;
        for (int k = 0; k < ARRAY_N; k++) begin
            v[k*DATA_W +: DATA_W] = DATA_W'(rand_range(lo, hi));
        end
        return v;
    endfunction

    task automatic load_weights(input logic [ARRAY_N*DATA_W-1:0] w, input int b, input int s);
        @(negedge clk);
        w_load_i = 1'b1;
        w_vec_i  = w;
        bias_i   = ACC_W'(b);
        shift_i  = SHIFT_W'(s);
        @(negedge clk);
        w_load_i = 1'b0;
    endtask

    task automatic send_burst(input int len, input int lo, input int hi);
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            x_valid_i = 1'b1;
            x_last_i  = (i == len - 1);
            x_vec_i   = rand_vec(lo, hi);
        end
        bursts_sent++;
    endtask

    task automatic end_stream();
        @(negedge clk);
        x_valid_i = 1'b0;
        x_last_i  = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done_seen < bursts_sent && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done_seen < bursts_sent) begin
            $display("timed out waiting for done_o in test %0d", test_id);
            timeout_cnt++;
        end
    endtask

    task automatic read_back(input int len);
        for (int a = 0; a < len; a++) begin
            @(negedge clk);
            rd_addr_i = ADDR_W'(a);
            rd_check  = 1'b1;
        end
        @(negedge clk);
        rd_check = 1'b0;
    endtask

    task automatic run_burst(input logic [ARRAY_N*DATA_W-1:0] w, input int b, input int s,
                             input int lo, input int hi);
        int len;
        len = len_tab[burst_no];
        burst_no++;
        load_weights(w, b, s);
        send_burst(len, lo, hi);
        end_stream();
        wait_done();
        read_back(len);
    endtask

    initial begin : main_seq
        int total;
        seed = 32'hd64f11e7;
        void'($urandom(seed));
        rst         = 1'b0;
        w_load_i    = 1'b0;
        w_vec_i     = '0;
        x_valid_i   = 1'b0;
        x_last_i    = 1'b0;
        x_vec_i     = '0;
        bias_i      = '0;
        shift_i     = '0;
        rd_addr_i   = '0;
        rd_check    = 1'b0;
        test_id     = 4'd0;
        done_seen   = 0;
        bursts_sent = 0;
        burst_no    = 0;
        timeout_cnt = 0;

        total = MARGIN;
        for (int i = 0; i < NUM_BURSTS; i++) begin
            len_tab[i] = rand_range(1, 2**ADDR_W);
            total      = total + 2 * len_tab[i] + BURST_COST;
        end
        cycle_budget = total;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        test_id = 4'd1;
        repeat (8) begin
            run_burst(rand_vec(-128, 127), rand_range(-4096, 4095), rand_range(0, 7), -128, 127);
        end

        // bias far beyond the dot product range
        test_id = 4'd2;
        run_burst(rand_vec(-128, 127), 200000, 0, -128, 127);
        run_burst(rand_vec(-128, 127), -200000, 0, -128, 127);

        // positive weights, so the input sign sets the result sign
        test_id = 4'd3;
        run_burst(rand_vec(1, 127), 0, rand_range(0, 3), -128, -1);
        run_burst(rand_vec(1, 127), 0, rand_range(0, 3), 1, 127);

        test_id = 4'd4;
        load_weights(rand_vec(-128, 127), rand_range(-2048, 2047), rand_range(0, 6));
        send_burst(len_tab[burst_no], -128, 127);
        send_burst(len_tab[burst_no+1], -128, 127);
        end_stream();
        wait_done();
        read_back(len_tab[burst_no+1]);
        burst_no = burst_no + 2;

        test_id = 4'd5;
        run_burst(rand_vec(-128, 127), rand_range(-512, 511), rand_range(0, 4), -128, 127);
        run_burst(rand_vec(-128, 127), rand_range(-512, 511), rand_range(0, 4), -128, 127);

        repeat (4) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures",
                 mismatch_cnt, fault_cnt + timeout_cnt);
        if (mismatch_cnt + fault_cnt + timeout_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* npu_tile.f */
npu_pkg.sv
acc_stream_if.sv
mac_pe.sv
mac_row.sv
requant_acc.sv
activation_relu.sv
result_buffer.sv
npu_tile.sv
npu_checker.sv
tb_npu_tile.sv

/* Bender.yml */
package:
  name: npu_tile

sources:
  - npu_pkg.sv
  - acc_stream_if.sv
  - mac_pe.sv
  - mac_row.sv
  - requant_acc.sv
  - activation_relu.sv
  - result_buffer.sv
  - npu_tile.sv
  - target: test
    files:
      - npu_checker.sv
      - tb_npu_tile.sv
